/* include/execCluster_defines.svh */
`ifndef EXECCLUSTER_DEFINES_SVH
`define EXECCLUSTER_DEFINES_SVH

// Datapath and tag widths.
`define XLEN 32
`define TAG_W 7
`define SQN_W 7

// Tag bit that marks a result without register write.
`define NO_RESULT_BIT 6

`define NUM_PREGS 64

// Functional unit timing.
`define MUL_STAGES 3
`define DIV_STEPS 32

`endif

/* src/execPkg.sv */
`default_nettype none
`include "execCluster_defines.svh"

package execPkg;

    typedef enum logic [1:0] {
        FU_INT,
        FU_MUL,
        FU_DIV
    } fuType;

    // Divider reads code 0 as quotient, code 1 as remainder.
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_MOVI
    } aluOp;

    typedef logic [2:0] fuMask; // One bit per fuType.

    typedef struct packed {
        logic [`TAG_W-2:0] srcTagA;
        logic [`TAG_W-2:0] srcTagB;
        logic useImm;
        logic [`XLEN-1:0] imm;
        logic [`TAG_W-1:0] dstTag;
        logic [`SQN_W-1:0] sqN;
        fuType fu;
        aluOp op;
    } issueUOp;

    typedef struct packed {
        logic valid;
        logic [`TAG_W-1:0] dstTag;
        logic [`SQN_W-1:0] sqN;
        fuType fu;
        aluOp op;
        logic [`XLEN-1:0] srcA;
        logic [`XLEN-1:0] srcB;
    } exUOp;

    typedef struct packed {
        logic valid;
        logic [`TAG_W-1:0] dstTag;
        logic [`SQN_W-1:0] sqN;
        logic [`XLEN-1:0] result;
    } resUOp;

    // Sequence numbers wrap, so compare by signed distance.
    function automatic logic youngerThan(input logic [`SQN_W-1:0] a,
                                         input logic [`SQN_W-1:0] b);
        logic signed [`SQN_W-1:0] diff;
        diff = a - b;
        return diff > 0;
    endfunction

endpackage

`default_nettype wire

/* src/physRegFile.sv */
`timescale 1ns/100ps
`default_nettype none
`include "execCluster_defines.svh"

module physRegFile (
    input wire clk,

    input wire [`TAG_W-2:0] rdTagA,
    input wire [`TAG_W-2:0] rdTagB,
    output logic [`XLEN-1:0] rdDataA,
    output logic [`XLEN-1:0] rdDataB,

    input wire execPkg::resUOp wb
);

    logic [`XLEN-1:0] regs [`NUM_PREGS];
    logic wrEn;

    assign wrEn = wb.valid && !wb.dstTag[`NO_RESULT_BIT]; // Tag bit 6 skips the write.

    always_ff @(posedge clk) begin
        if (wrEn) begin
            regs[wb.dstTag[`TAG_W-2:0]] <= wb.result;
        end
    end

    // Same-cycle writes are covered by the bypass in the issue stage.
    assign rdDataA = regs[rdTagA];
    assign rdDataB = regs[rdTagB];

endmodule

`default_nettype wire

/* src/issueStage.sv */
`timescale 1ns/100ps
`default_nettype none
`include "execCluster_defines.svh"

module issueStage (
    input wire clk,
    input wire rstN,

    input wire issueValid,
    input wire execPkg::issueUOp issueUop,

    input wire execPkg::resUOp wb,
    input wire divBusy,

    output logic [`TAG_W-2:0] rdTagA,
    output logic [`TAG_W-2:0] rdTagB,
    input wire [`XLEN-1:0] rdDataA,
    input wire [`XLEN-1:0] rdDataB,

    output execPkg::exUOp exUop,
    output execPkg::fuMask blockFu
);

    import execPkg::*;

    logic wbWrites;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    exUOp exNext;
    logic [1:0] mulResv;

    assign rdTagA = issueUop.srcTagA;
    assign rdTagB = issueUop.srcTagB;

    assign wbWrites = wb.valid && !wb.dstTag[`NO_RESULT_BIT];

    // Writeback in the issue cycle wins over the register file.
    always_comb begin
        opA = rdDataA;
        opB = rdDataB;
        if (wbWrites && wb.dstTag[`TAG_W-2:0] == issueUop.srcTagA) begin
            opA = wb.result;
        end
        if (wbWrites && wb.dstTag[`TAG_W-2:0] == issueUop.srcTagB) begin
            opB = wb.result;
        end
    end

    always_comb begin
        exNext.valid = issueValid;
        exNext.dstTag = issueUop.dstTag;
        exNext.sqN = issueUop.sqN;
        exNext.fu = issueUop.fu;
        exNext.op = issueUop.op;
        exNext.srcA = opA;
        exNext.srcB = issueUop.useImm ? issueUop.imm : opB;
    end

    always_ff @(posedge clk) begin
        exUop <= exNext;
        mulResv <= {mulResv[0], issueValid && issueUop.fu == FU_MUL};
        if (!rstN) begin
            exUop.valid <= 1'b0;
            mulResv <= '0;
        end
    end

    // An ALU op two edges behind a multiply would hit the same writeback slot.
    always_comb begin
        blockFu = '0;
        blockFu[FU_INT] = mulResv[1];
        blockFu[FU_DIV] = divBusy || (exUop.valid && exUop.fu == FU_DIV);
    end

endmodule

`default_nettype wire

/* src/intAlu.sv */
`timescale 1ns/100ps
`default_nettype none
`include "execCluster_defines.svh"

module intAlu (
    input wire clk,
    input wire rstN,

    input wire execPkg::exUOp exUop,

    input wire flush,
    input wire [`SQN_W-1:0] flushSqN,

    output execPkg::resUOp res
);

    import execPkg::*;

    logic lastFlush;
    logic [`SQN_W-1:0] lastFlushSqN;
    logic kill;
    logic [`XLEN-1:0] result;

    // Last cycle's flush covers an op issued in the flush cycle.
    assign kill = (flush && youngerThan(exUop.sqN, flushSqN)) ||
                  (lastFlush && youngerThan(exUop.sqN, lastFlushSqN));

    always_comb begin
        case (exUop.op)
            OP_ADD: result = exUop.srcA + exUop.srcB;
            OP_SUB: result = exUop.srcA - exUop.srcB;
            OP_AND: result = exUop.srcA & exUop.srcB;
            OP_OR: result = exUop.srcA | exUop.srcB;
            OP_XOR: result = exUop.srcA ^ exUop.srcB;
            OP_SLL: result = exUop.srcA << exUop.srcB[$clog2(`XLEN)-1:0];
            default: result = exUop.srcB; // MOVI.
        endcase
    end

    always_ff @(posedge clk) begin
        lastFlush <= flush;
        lastFlushSqN <= flushSqN;
        res.dstTag <= exUop.dstTag;
        res.sqN <= exUop.sqN;
        res.result <= result;
        res.valid <= exUop.valid && exUop.fu == FU_INT && !kill;
        if (!rstN) begin
            lastFlush <= 1'b0;
            res.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/multiplier.sv */
`timescale 1ns/100ps
`default_nettype none
`include "execCluster_defines.svh"

module multiplier (
    input wire clk,
    input wire rstN,

    input wire execPkg::exUOp exUop,

    input wire flush,
    input wire [`SQN_W-1:0] flushSqN,

    output execPkg::resUOp res
);

    import execPkg::*;

    localparam HALF = `XLEN / 2;

    logic lastFlush;
    logic [`SQN_W-1:0] lastFlushSqN;
    logic startKill;
    resUOp s1; // Result field holds the low partial product.
    resUOp s2;
    logic [HALF-1:0] s1HL;
    logic [HALF-1:0] s1LH;
    logic [HALF-1:0] s2Cross;

    assign startKill = (flush && youngerThan(exUop.sqN, flushSqN)) ||
                       (lastFlush && youngerThan(exUop.sqN, lastFlushSqN));

    // Only the low half of the product is kept, so cross terms need HALF bits.
    always_ff @(posedge clk) begin
        lastFlush <= flush;
        lastFlushSqN <= flushSqN;

        s1.dstTag <= exUop.dstTag;
        s1.sqN <= exUop.sqN;
        s1.result <= exUop.srcA[HALF-1:0] * exUop.srcB[HALF-1:0];
        s1HL <= exUop.srcA[`XLEN-1:HALF] * exUop.srcB[HALF-1:0];
        s1LH <= exUop.srcA[HALF-1:0] * exUop.srcB[`XLEN-1:HALF];
        s1.valid <= exUop.valid && exUop.fu == FU_MUL && !startKill;

        s2 <= s1;
        s2Cross <= s1HL + s1LH;
        s2.valid <= s1.valid && !(flush && youngerThan(s1.sqN, flushSqN));

        res <= s2;
        res.result <= s2.result + {s2Cross, {HALF{1'b0}}};
        res.valid <= s2.valid && !(flush && youngerThan(s2.sqN, flushSqN));

        if (!rstN) begin
            lastFlush <= 1'b0;
            s1.valid <= 1'b0;
            s2.valid <= 1'b0;
            res.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/divider.sv */
`timescale 1ns/100ps
`default_nettype none
`include "execCluster_defines.svh"

module divider (
    input wire clk,
    input wire rstN,

    input wire execPkg::exUOp exUop,

    input wire flush,
    input wire [`SQN_W-1:0] flushSqN,

    input wire wbFree,
    output logic divBusy,

    output execPkg::resUOp res
);

    import execPkg::*;

    localparam CNT_W = $clog2(`DIV_STEPS);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_HOLD
    } divState;

    divState state;
    logic [CNT_W-1:0] stepCnt;
    logic [`XLEN-1:0] quo;
    logic [`XLEN-1:0] rem;
    logic [`XLEN-1:0] divisor;
    logic wantRem;
    logic [`TAG_W-1:0] dstTag;
    logic [`SQN_W-1:0] sqN;
    logic lastFlush;
    logic [`SQN_W-1:0] lastFlushSqN;
    logic startKill;
    logic start;
    logic runKill;
    logic [`XLEN:0] shifted;
    logic fits;

    assign startKill = (flush && youngerThan(exUop.sqN, flushSqN)) ||
                       (lastFlush && youngerThan(exUop.sqN, lastFlushSqN));
    assign start = exUop.valid && exUop.fu == FU_DIV && !startKill;
    assign runKill = flush && youngerThan(sqN, flushSqN);

    // Restoring step. A zero divisor always fits, giving all ones and rem = dividend.
    assign shifted = {rem, quo[`XLEN-1]};
    assign fits = shifted >= {1'b0, divisor};

    always_ff @(posedge clk) begin
        lastFlush <= flush;
        lastFlushSqN <= flushSqN;
        case (state)
            DIV_IDLE: begin
                if (start) begin
                    state <= DIV_RUN;
                    stepCnt <= CNT_W'(`DIV_STEPS - 1);
                    quo <= exUop.srcA;
                    rem <= '0;
                    divisor <= exUop.srcB;
                    wantRem <= exUop.op[0]; // Code 1 is remainder.
                    dstTag <= exUop.dstTag;
                    sqN <= exUop.sqN;
                end
            end
            DIV_RUN: begin
                if (fits) begin
                    rem <= `XLEN'(shifted - {1'b0, divisor});
                end else begin
                    rem <= shifted[`XLEN-1:0];
                end
                quo <= {quo[`XLEN-2:0], fits};
                stepCnt <= stepCnt - 1'b1;
                if (stepCnt == '0) begin
                    state <= DIV_HOLD;
                end
            end
            default: begin
                if (wbFree) begin
                    state <= DIV_IDLE; // Result taken by the bus.
                end
            end
        endcase
        if (state != DIV_IDLE && runKill) begin
            state <= DIV_IDLE;
        end
        if (!rstN) begin
            state <= DIV_IDLE;
            lastFlush <= 1'b0;
        end
    end

    assign divBusy = state != DIV_IDLE;

    assign res.valid = state == DIV_HOLD;
    assign res.dstTag = dstTag;
    assign res.sqN = sqN;
    assign res.result = wantRem ? rem : quo;

endmodule

`default_nettype wire

/* src/writebackArbiter.sv */
`timescale 1ns/100ps
`default_nettype none
`include "execCluster_defines.svh"

module writebackArbiter (
    input wire execPkg::resUOp aluRes,
    input wire execPkg::resUOp mulRes,
    input wire execPkg::resUOp divRes,

    output execPkg::resUOp wbUop,
    output logic wbWrite,
    output logic wbFree
);

    // Fixed priority. The divider is the only unit that can wait.
    always_comb begin
        if (aluRes.valid) begin
            wbUop = aluRes;
        end else if (mulRes.valid) begin
            wbUop = mulRes;
        end else begin
            wbUop = divRes;
        end
    end

    assign wbFree = !aluRes.valid && !mulRes.valid;

    assign wbWrite = wbUop.valid && !wbUop.dstTag[`NO_RESULT_BIT];

endmodule

`default_nettype wire

/* src/execCluster.sv */
`timescale 1ns/100ps
`default_nettype none
`include "execCluster_defines.svh"

module execCluster (
    input wire clk,
    input wire rstN,

    input wire issueValid,
    input wire execPkg::issueUOp issueUop,

    input wire flush,
    input wire [`SQN_W-1:0] flushSqN,

    output execPkg::fuMask blockFu,
    output execPkg::resUOp wbUop,
    output logic wbWrite
);

    import execPkg::*;

    logic [`TAG_W-2:0] rdTagA;
    logic [`TAG_W-2:0] rdTagB;
    logic [`XLEN-1:0] rdDataA;
    logic [`XLEN-1:0] rdDataB;
    exUOp exUop;
    resUOp aluRes;
    resUOp mulRes;
    resUOp divRes;
    logic wbFree;
    logic divBusy;

    issueStage iss (
        .clk(clk),
        .rstN(rstN),
        .issueValid(issueValid),
        .issueUop(issueUop),
        .wb(wbUop),
        .divBusy(divBusy),
        .rdTagA(rdTagA),
        .rdTagB(rdTagB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .exUop(exUop),
        .blockFu(blockFu)
    );

    physRegFile rf (
        .clk(clk),
        .rdTagA(rdTagA),
        .rdTagB(rdTagB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wb(wbUop)
    );

    intAlu ialu (
        .clk(clk),
        .rstN(rstN),
        .exUop(exUop),
        .flush(flush),
        .flushSqN(flushSqN),
        .res(aluRes)
    );

    multiplier mul (
        .clk(clk),
        .rstN(rstN),
        .exUop(exUop),
        .flush(flush),
        .flushSqN(flushSqN),
        .res(mulRes)
    );

    divider div (
        .clk(clk),
        .rstN(rstN),
        .exUop(exUop),
        .flush(flush),
        .flushSqN(flushSqN),
        .wbFree(wbFree),
        .divBusy(divBusy),
        .res(divRes)
    );

    writebackArbiter wbArb (
        .aluRes(aluRes),
        .mulRes(mulRes),
        .divRes(divRes),
        .wbUop(wbUop),
        .wbWrite(wbWrite),
        .wbFree(wbFree)
    );

endmodule

`default_nettype wire

/* dv/execCluster_properties.sv */
`timescale 1ns/100ps
`default_nettype none
`include "execCluster_defines.svh"

module execCluster_properties (
    input wire clk,
    input wire rstN,
    input wire issueValid,
    input wire execPkg::issueUOp issueUop,
    input wire execPkg::fuMask blockFu,
    input wire execPkg::resUOp wbUop,
    input wire wbWrite
);

    int failCount = 0; // Assertion failures so far.

    // Outside must honor the block levels.
    issueNotBlocked: assert property (
        @(posedge clk) disable iff (!rstN)
        issueValid |-> !blockFu[issueUop.fu]
    ) else begin
        failCount++;
        $error("issue sampled while its blockFu bit is set");
    end

    // First cycle out of reset carries no result.
    resetQuiet: assert property (
        @(posedge clk)
        rstN && !$past(rstN) |-> !wbUop.valid
    ) else begin
        failCount++;
        $error("wbUop valid right after reset release");
    end

    noWriteOnNoResult: assert property (
        @(posedge clk) disable iff (!rstN)
        wbWrite |-> !wbUop.dstTag[`NO_RESULT_BIT]
    ) else begin
        failCount++;
        $error("wbWrite high with no-result tag bit set");
    end

endmodule

`default_nettype wire

/* dv/execCluster_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "execCluster_defines.svh"

module execCluster_tb;

    import execPkg::*;

    localparam K_ISSUE = 0;
    localparam K_FLUSH = 1;
    localparam K_WAIT = 2;
    localparam K_FLUSHISSUE = 3; // Flush plus an issue in the same cycle.
    localparam DIV_QUO = 0;
    localparam DIV_REM = 1;

    typedef struct packed {
        logic [1:0] kind;
        logic noWait;
        logic [1:0] fu;
        logic [2:0] op;
        logic [5:0] srcA;
        logic [5:0] srcB;
        logic useImm;
        logic [31:0] imm; // Cycle count for wait rows.
        logic [6:0] dst;
        logic [6:0] sqN;
        logic [6:0] flushSq;
        logic [31:0] exp;
    } tableRow;

    logic clk;
    logic rstN;
    logic issueValid;
    issueUOp issueUop;
    logic flush;
    logic [`SQN_W-1:0] flushSqN;
    fuMask blockFu;
    resUOp wbUop;
    logic wbWrite;

    tableRow rows[$];
    logic expValid[128]; // Scoreboard, indexed by tag.
    logic [31:0] expVal[128];
    logic [6:0] expSq[128];
    logic expDiv[128];
    int expCycle[128];
    int cycleCnt;
    int sbCount;
    int divPending;
    logic tableReady;
    logic prevNoWait;
    integer seed;

    execCluster dut0 (
        .clk(clk),
        .rstN(rstN),
        .issueValid(issueValid),
        .issueUop(issueUop),
        .flush(flush),
        .flushSqN(flushSqN),
        .blockFu(blockFu),
        .wbUop(wbUop),
        .wbWrite(wbWrite)
    );

    bind execCluster execCluster_properties props0 (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt++; // Rising edges since start.
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            failRun($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic logic younger(input logic [6:0] a, input logic [6:0] b);
        logic signed [6:0] d;
        d = a - b;
        return d > 0;
    endfunction

    function automatic logic [31:0] refResult(input int fu, input int op,
                                              input logic [31:0] a, input logic [31:0] b);
        if (fu == FU_MUL) begin
            return a * b; // Low half only.
        end
        if (fu == FU_DIV) begin
            if (b == 0) begin
                return op[0] ? a : 32'hffff_ffff;
            end
            return op[0] ? a % b : a / b;
        end
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_OR: return a | b;
            OP_XOR: return a ^ b;
            OP_SLL: return a << b[4:0];
            default: return b;
        endcase
    endfunction

    task automatic addRow(input int kind, input bit noWait, input int fu, input int op,
                          input int srcA, input int srcB, input bit useImm,
                          input logic [31:0] imm, input int dst, input int sqN,
                          input int flushSq, input logic [31:0] exp);
        tableRow r;
        r.kind = kind;
        r.noWait = noWait;
        r.fu = fu;
        r.op = op;
        r.srcA = srcA;
        r.srcB = srcB;
        r.useImm = useImm;
        r.imm = imm;
        r.dst = dst;
        r.sqN = sqN;
        r.flushSq = flushSq;
        r.exp = exp;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        addRow(K_ISSUE, 0, FU_INT, OP_MOVI, 0, 0, 1, 32'h1234_5678, 1, 1, 0, 32'h1234_5678);
        addRow(K_ISSUE, 0, FU_INT, OP_MOVI, 0, 0, 1, 32'h0000_00f0, 2, 2, 0, 32'h0000_00f0);
        addRow(K_ISSUE, 0, FU_INT, OP_ADD, 1, 2, 0, 0, 3, 3, 0, 32'h1234_5768);
        addRow(K_ISSUE, 0, FU_INT, OP_SUB, 1, 2, 0, 0, 4, 4, 0, 32'h1234_5588);
        addRow(K_ISSUE, 0, FU_INT, OP_AND, 1, 0, 1, 32'hff00_ff00, 5, 5, 0, 32'h1200_5600);
        addRow(K_ISSUE, 0, FU_INT, OP_OR, 2, 0, 1, 32'h0000_000f, 6, 6, 0, 32'h0000_00ff);
        addRow(K_ISSUE, 0, FU_INT, OP_XOR, 1, 0, 1, 32'hffff_ffff, 7, 7, 0, 32'hedcb_a987);
        addRow(K_ISSUE, 0, FU_INT, OP_SLL, 2, 0, 1, 32'h4, 8, 8, 0, 32'h0000_0f00);
        addRow(K_ISSUE, 1, FU_MUL, 0, 1, 2, 0, 0, 9, 9, 0, 32'h1111_1080); // Back to back.
        addRow(K_ISSUE, 1, FU_MUL, 0, 2, 2, 0, 0, 10, 10, 0, 32'h0000_e100);
        addRow(K_ISSUE, 0, FU_MUL, 0, 1, 0, 1, 32'h3, 11, 11, 0, 32'h369d_0368);
        addRow(K_ISSUE, 0, FU_MUL, 0, 2, 0, 1, 32'h2, 12, 12, 0, 32'h0000_01e0);
        addRow(K_ISSUE, 0, FU_DIV, DIV_QUO, 1, 0, 1, 32'h10, 13, 13, 0, 32'h0123_4567);
        addRow(K_ISSUE, 0, FU_DIV, DIV_REM, 1, 0, 1, 32'h100, 14, 14, 0, 32'h0000_0078);
        addRow(K_ISSUE, 0, FU_DIV, DIV_QUO, 1, 0, 1, 32'h0, 15, 15, 0, 32'hffff_ffff);
        addRow(K_ISSUE, 0, FU_DIV, DIV_REM, 1, 0, 1, 32'h0, 16, 16, 0, 32'h1234_5678);
        addRow(K_ISSUE, 0, FU_INT, OP_ADD, 1, 0, 1, 32'h1, 7'h45, 17, 0, 32'h1234_5679);
        addRow(K_ISSUE, 0, FU_INT, OP_ADD, 5, 0, 1, 32'h0, 17, 18, 0, 32'h1200_5600);
        addRow(K_ISSUE, 1, FU_DIV, DIV_QUO, 1, 0, 1, 32'h7, 18, 40, 0, 32'h0);
        addRow(K_WAIT, 1, 0, 0, 0, 0, 0, 32'd5, 0, 0, 0, 32'h0);
        addRow(K_FLUSH, 0, 0, 0, 0, 0, 0, 0, 0, 0, 30, 32'h0); // Divide in progress dropped.
        addRow(K_ISSUE, 1, FU_DIV, DIV_QUO, 1, 0, 1, 32'h1000, 19, 50, 0, 32'h0001_2345);
        addRow(K_WAIT, 1, 0, 0, 0, 0, 0, 32'd3, 0, 0, 0, 32'h0);
        addRow(K_FLUSH, 0, 0, 0, 0, 0, 0, 0, 0, 0, 60, 32'h0); // Older divide survives.
        addRow(K_ISSUE, 1, FU_MUL, 0, 1, 0, 1, 32'h1, 20, 70, 0, 32'h1234_5678);
        addRow(K_ISSUE, 1, FU_MUL, 0, 2, 0, 1, 32'h1, 21, 72, 0, 32'h0);
        addRow(K_FLUSHISSUE, 0, FU_MUL, 0, 1, 0, 1, 32'h2, 22, 73, 71, 32'h0);
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        addRow(K_ISSUE, 0, FU_INT, OP_MOVI, 0, 0, 1, r1, 30, 80, 0, r1);
        addRow(K_ISSUE, 0, FU_INT, OP_MOVI, 0, 0, 1, r2, 31, 81, 0, r2);
        addRow(K_ISSUE, 0, FU_INT, OP_ADD, 30, 31, 0, 0, 32, 82, 0,
               refResult(FU_INT, OP_ADD, r1, r2));
        addRow(K_ISSUE, 0, FU_MUL, 0, 30, 31, 0, 0, 33, 83, 0, refResult(FU_MUL, 0, r1, r2));
        addRow(K_ISSUE, 0, FU_DIV, DIV_QUO, 30, 31, 0, 0, 34, 84, 0,
               refResult(FU_DIV, DIV_QUO, r1, r2));
        addRow(K_ISSUE, 0, FU_DIV, DIV_REM, 30, 31, 0, 0, 35, 85, 0,
               refResult(FU_DIV, DIV_REM, r1, r2));
        addRow(K_ISSUE, 0, FU_INT, OP_XOR, 30, 0, 1, r3, 36, 86, 0,
               refResult(FU_INT, OP_XOR, r1, r3));
    endtask

    // Drives the uop and books its expected result.
    task automatic driveIssue(input tableRow r);
        while (blockFu[r.fu]) @(negedge clk);
        issueUop.srcTagA = r.srcA;
        issueUop.srcTagB = r.srcB;
        issueUop.useImm = r.useImm;
        issueUop.imm = r.imm;
        issueUop.dstTag = r.dst;
        issueUop.sqN = r.sqN;
        issueUop.fu = fuType'(r.fu);
        issueUop.op = aluOp'(r.op);
        issueValid = 1'b1;
        expValid[r.dst] = 1'b1;
        expVal[r.dst] = r.exp;
        expSq[r.dst] = r.sqN;
        expDiv[r.dst] = r.fu == FU_DIV;
        expCycle[r.dst] = cycleCnt + (r.fu == FU_MUL ? 4 : 2); // ALU 2, multiply 4.
        sbCount++;
    endtask

    task automatic dropYounger(input logic [6:0] f);
        for (int t = 0; t < 128; t++) begin
            if (expValid[t] && younger(expSq[t], f)) begin
                expValid[t] = 1'b0;
                sbCount--;
                if (expDiv[t]) divPending--;
            end
        end
    endtask

    task automatic applyRow(input tableRow r);
        if (r.kind == K_WAIT) begin
            repeat (r.imm) @(negedge clk);
        end else if (r.kind == K_ISSUE) begin
            driveIssue(r);
            @(negedge clk);
            issueValid = 1'b0;
            if (r.fu == FU_DIV) divPending++;
            if (r.fu == FU_MUL && !r.noWait && !prevNoWait) begin
                check("blockFu[FU_INT]", 0, blockFu[FU_INT]);
                @(negedge clk);
                check("blockFu[FU_INT]", 1, blockFu[FU_INT]); // Slot two edges on.
                @(negedge clk);
                check("blockFu[FU_INT]", 0, blockFu[FU_INT]);
            end
        end else begin
            if (r.kind == K_FLUSHISSUE) driveIssue(r);
            flush = 1'b1;
            flushSqN = r.flushSq;
            @(posedge clk);
            #1;
            if (r.kind == K_FLUSHISSUE && r.fu == FU_DIV) divPending++;
            dropYounger(r.flushSq);
            @(negedge clk);
            flush = 1'b0;
            issueValid = 1'b0;
        end
        if (!r.noWait) begin
            while (sbCount != 0) @(negedge clk);
        end
    endtask

    // Results are compared where the bus is stable.
    always @(negedge clk) begin
        if (rstN && divPending > 0) begin
            check("blockFu[FU_DIV]", 1, blockFu[FU_DIV]);
        end
        if (rstN && wbUop.valid) begin
            if (!expValid[wbUop.dstTag]) begin
                failRun($sformatf("ERR wbUop.dstTag %h was not expected", wbUop.dstTag));
            end else begin
                check("wbUop.result", expVal[wbUop.dstTag], wbUop.result);
                check("wbUop.sqN", expSq[wbUop.dstTag], wbUop.sqN);
                check("wbWrite", !wbUop.dstTag[`NO_RESULT_BIT], wbWrite);
                if (!expDiv[wbUop.dstTag]) begin
                    check("wbUop cycle", expCycle[wbUop.dstTag], cycleCnt);
                end
                expValid[wbUop.dstTag] = 1'b0;
                sbCount--;
                if (expDiv[wbUop.dstTag]) divPending--;
            end
        end
    end

    initial begin
        wait (tableReady);
        repeat (rows.size() * 60 + 20) @(posedge clk);
        failRun("Timeout: the run did not finish in time.");
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        issueValid = 1'b0;
        issueUop = '0;
        flush = 1'b0;
        flushSqN = '0;
        cycleCnt = 0;
        sbCount = 0;
        divPending = 0;
        prevNoWait = 1'b0;
        tableReady = 1'b0;
        seed = 32'h040d_8c2e;
        for (int t = 0; t < 128; t++) begin
            expValid[t] = 1'b0;
            expDiv[t] = 1'b0;
            expCycle[t] = 0;
        end
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        repeat (2) @(negedge clk);
        foreach (rows[i]) begin
            applyRow(rows[i]);
            prevNoWait = rows[i].noWait;
        end
        repeat (20) @(negedge clk); // Catch stray writebacks.
        check("scoreboard count", 0, sbCount);
        if (dut0.props0.failCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            failRun("Bound assertions reported failures during the run.");
        end
    end

endmodule

`default_nettype wire

/* execCluster.f */
+incdir+include
src/execPkg.sv
src/physRegFile.sv
src/issueStage.sv
src/intAlu.sv
src/multiplier.sv
src/divider.sv
src/writebackArbiter.sv
src/execCluster.sv
dv/execCluster_properties.sv
dv/execCluster_tb.sv
